//--- design/mrd_cfg.svh
`ifndef MRD_CFG_SVH
`define MRD_CFG_SVH

// ------------------------------
// memory geometry
// ------------------------------

// 7 banks keep radix-2..5 operands apart
`define MRD_NUM_BANKS 7
// rows per bank as address bits
`define MRD_ROW_W 9
// linear sample address over all 7 * 512 points
`define MRD_ADDR_W 12

// ------------------------------
// datapath and transform limits
// ------------------------------

// per real or imaginary part
`define MRD_SMP_W 18
`define MRD_MAX_RDX 5
`define MRD_MAX_STG 3

`endif

//--- design/mrd_data_pkg.sv
`include "mrd_cfg.svh"

package mrd_data_pkg;

	typedef logic [`MRD_ADDR_W-1:0] addr_t;
	typedef logic [`MRD_ROW_W-1:0] row_t;
	// value 7 marks an unused lane
	typedef logic [$clog2(`MRD_NUM_BANKS + 1)-1:0] bank_t;

	typedef struct packed
	{
		logic signed [`MRD_SMP_W-1:0] re;
		logic signed [`MRD_SMP_W-1:0] im;
	} sample_t;

	// operands of one butterfly
	// lanes at or above the radix are zero
	typedef struct packed
	{
		logic [2:0]                     radix;
		logic [1:0]                     stage;
		sample_t [`MRD_MAX_RDX-1:0]     smp;
	} rd_group_t;

	// bank is the address mod 7, row the quotient
	function automatic void bank_split(input addr_t addr, output bank_t bank,
		output row_t row);
		bank = bank_t'(addr % `MRD_NUM_BANKS);
		row = row_t'(addr / `MRD_NUM_BANKS);
	endfunction

endpackage

//--- design/mrd_ctrl_pkg.sv
`include "mrd_cfg.svh"

package mrd_ctrl_pkg;

	typedef logic [2:0] radix_t;
	typedef logic [1:0] stage_t;

	// rdx[0] is the first stage, n_stg from 1 to 3
	typedef struct packed
	{
		stage_t                     n_stg;
		radix_t [`MRD_MAX_STG-1:0]  rdx;
	} xform_cfg_t;

	typedef enum logic [1:0]
	{
		SEQ_IDLE,
		SEQ_READ,
		SEQ_GAP
	} seq_state_t;

	typedef struct packed
	{
		logic                   valid;
		stage_t                 stage;
		radix_t                 radix;
		mrd_data_pkg::addr_t    base;
		mrd_data_pkg::addr_t    offset;
		mrd_data_pkg::addr_t    stride;
		logic                   last;
	} bfly_cmd_t;

endpackage

//--- design/mrd_stage_seq.sv
`timescale 1ns/1ps
`include "mrd_cfg.svh"

module mrd_stage_seq
(
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        start,
	input  mrd_ctrl_pkg::xform_cfg_t    cfg,
	output mrd_ctrl_pkg::bfly_cmd_t     cmd,
	output logic                        busy
);
	import mrd_ctrl_pkg::*;
	import mrd_data_pkg::*;

	// cycles from the last command until its group has left the memory
	localparam logic [2:0] DRAIN = 3'd4;

	seq_state_t state;
	xform_cfg_t cfg_r;
	stage_t     stg;
	addr_t      off;
	addr_t      blk;
	addr_t      base;
	logic [2:0] drain;

	addr_t      stride_tab [`MRD_MAX_STG];
	addr_t      blocks_tab [`MRD_MAX_STG];
	radix_t     rdx;
	addr_t      stride;
	addr_t      blocks;
	addr_t      span;
	logic       off_end;
	logic       blk_end;
	logic       stg_end;

	// ------------------------------
	// stage geometry
	// ------------------------------
	// stride from later stages, block count from earlier ones
	always_comb
	begin
		for (int s = 0; s < `MRD_MAX_STG; s++)
		begin
			stride_tab[s] = addr_t'(1);
			blocks_tab[s] = addr_t'(1);
			for (int j = 0; j < `MRD_MAX_STG; j++)
			begin
				if (j > s && j < int'(cfg_r.n_stg))
					stride_tab[s] = stride_tab[s] * cfg_r.rdx[j];
				if (j < s)
					blocks_tab[s] = blocks_tab[s] * cfg_r.rdx[j];
			end
		end
	end

	assign rdx = cfg_r.rdx[stg];
	assign stride = stride_tab[stg];
	assign blocks = blocks_tab[stg];
	// distance between consecutive block bases
	assign span = stride * rdx;

	assign off_end = (off == stride - addr_t'(1));
	assign blk_end = (blk == blocks - addr_t'(1));
	assign stg_end = (stg == stage_t'(cfg_r.n_stg - 2'd1));

	always_comb
	begin
		cmd.valid = (state == SEQ_READ);
		cmd.stage = stg;
		cmd.radix = rdx;
		cmd.base = base;
		cmd.offset = off;
		cmd.stride = stride;
		cmd.last = off_end && blk_end && stg_end;
	end

	assign busy = (state != SEQ_IDLE);

	always_ff @(posedge clk)
	begin
		if (state == SEQ_IDLE && start)
			cfg_r <= cfg;
	end

	// ------------------------------
	// butterfly walk
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= SEQ_IDLE;
			stg <= '0;
			off <= '0;
			blk <= '0;
			base <= '0;
			drain <= '0;
		end
		else
		begin
			case (state)
				SEQ_IDLE:
				begin
					if (start)
					begin
						state <= SEQ_READ;
						stg <= '0;
						off <= '0;
						blk <= '0;
						base <= '0;
					end
				end
				SEQ_READ:
				begin
					if (!off_end)
						off <= off + addr_t'(1);
					else if (!blk_end)
					begin
						off <= '0;
						blk <= blk + addr_t'(1);
						base <= base + span;
					end
					else
					begin
						off <= '0;
						blk <= '0;
						base <= '0;
						state <= SEQ_GAP;
						// zero means one gap cycle, then the next stage
						if (stg_end)
							drain <= DRAIN;
						else
						begin
							stg <= stg + stage_t'(1);
							drain <= '0;
						end
					end
				end
				SEQ_GAP:
				begin
					if (drain == 3'd0)
						state <= SEQ_READ;
					else if (drain == 3'd1)
						state <= SEQ_IDLE;
					else
						drain <= drain - 3'd1;
				end
				default:
					state <= SEQ_IDLE;
			endcase
		end
	end

endmodule

//--- design/mrd_bfly_addr.sv
`timescale 1ns/1ps
`include "mrd_cfg.svh"

module mrd_bfly_addr
(
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  mrd_ctrl_pkg::bfly_cmd_t                 cmd,
	output logic                                    op_valid,
	output logic                                    op_last,
	output mrd_ctrl_pkg::radix_t                    op_radix,
	output mrd_ctrl_pkg::stage_t                    op_stage,
	output mrd_data_pkg::addr_t [`MRD_MAX_RDX-1:0]  op_addr
);
	import mrd_ctrl_pkg::*;
	import mrd_data_pkg::*;

	// beyond the last row of the last bank
	localparam addr_t ADDR_NONE = '1;

	addr_t start_r;
	addr_t stride_r;
	addr_t walk;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			op_valid <= 1'b0;
			op_last <= 1'b0;
		end
		else
		begin
			op_valid <= cmd.valid;
			op_last <= cmd.valid && cmd.last;
		end
	end

	// operand 0 of the butterfly
	always_ff @(posedge clk)
	begin
		start_r <= cmd.base + cmd.offset;
		stride_r <= cmd.stride;
		op_radix <= cmd.radix;
		op_stage <= cmd.stage;
	end

	// ------------------------------
	// lane addresses
	// ------------------------------
	// one stride step per lane, unused lanes get the marker
	always_comb
	begin
		walk = start_r;
		for (int m = 0; m < `MRD_MAX_RDX; m++)
		begin
			if (m < int'(op_radix))
				op_addr[m] = walk;
			else
				op_addr[m] = ADDR_NONE;
			walk = walk + stride_r;
		end
	end

endmodule

//--- design/mrd_bank_map.sv
`timescale 1ns/1ps
`include "mrd_cfg.svh"

module mrd_bank_map
(
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    op_valid,
	input  logic                                    op_last,
	input  mrd_ctrl_pkg::radix_t                    op_radix,
	input  mrd_ctrl_pkg::stage_t                    op_stage,
	input  mrd_data_pkg::addr_t [`MRD_MAX_RDX-1:0]  op_addr,
	output logic [`MRD_NUM_BANKS-1:0]               rd_en,
	output mrd_data_pkg::row_t [`MRD_NUM_BANKS-1:0] rd_row,
	output mrd_data_pkg::bank_t [`MRD_MAX_RDX-1:0]  lane_bank,
	output logic                                    req_valid,
	output logic                                    req_last,
	output mrd_ctrl_pkg::radix_t                    req_radix,
	output mrd_ctrl_pkg::stage_t                    req_stage
);
	import mrd_ctrl_pkg::*;
	import mrd_data_pkg::*;

	localparam int unsigned NUM_WORDS = `MRD_NUM_BANKS << `MRD_ROW_W;
	localparam bank_t BANK_NONE = bank_t'(`MRD_NUM_BANKS);

	bank_t [`MRD_MAX_RDX-1:0]   lane_bank_c;
	row_t [`MRD_MAX_RDX-1:0]    lane_row_c;
	logic [`MRD_NUM_BANKS-1:0]  hit_c;
	row_t [`MRD_NUM_BANKS-1:0]  row_c;

	// ------------------------------
	// split each lane
	// ------------------------------
	always_comb
	begin
		for (int m = 0; m < `MRD_MAX_RDX; m++)
		begin
			bank_split(op_addr[m], lane_bank_c[m], lane_row_c[m]);
			// marker lanes from the address stage
			if (op_addr[m] >= addr_t'(NUM_WORDS))
				lane_bank_c[m] = BANK_NONE;
		end
	end

	// lowest lane wins
	always_comb
	begin
		hit_c = '0;
		row_c = '0;
		for (int k = 0; k < `MRD_NUM_BANKS; k++)
		begin
			for (int m = `MRD_MAX_RDX - 1; m >= 0; m--)
			begin
				if (lane_bank_c[m] == bank_t'(k))
				begin
					hit_c[k] = 1'b1;
					row_c[k] = lane_row_c[m];
				end
			end
		end
	end

	// ------------------------------
	// request registers
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_en <= '0;
			req_valid <= 1'b0;
			req_last <= 1'b0;
		end
		else
		begin
			rd_en <= op_valid ? hit_c : '0;
			req_valid <= op_valid;
			req_last <= op_valid && op_last;
		end
	end

	always_ff @(posedge clk)
	begin
		rd_row <= row_c;
		lane_bank <= lane_bank_c;
		req_radix <= op_radix;
		req_stage <= op_stage;
	end

endmodule

//--- design/mrd_bank_mem.sv
`timescale 1ns/1ps
`include "mrd_cfg.svh"

module mrd_bank_mem
(
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    wr_valid,
	input  mrd_data_pkg::addr_t                     wr_addr,
	input  mrd_data_pkg::sample_t                   wr_data,
	input  logic [`MRD_NUM_BANKS-1:0]               rd_en,
	input  mrd_data_pkg::row_t [`MRD_NUM_BANKS-1:0] rd_row,
	input  mrd_data_pkg::bank_t [`MRD_MAX_RDX-1:0]  lane_bank,
	input  logic                                    req_valid,
	input  logic                                    req_last,
	input  mrd_ctrl_pkg::radix_t                    req_radix,
	input  mrd_ctrl_pkg::stage_t                    req_stage,
	output logic                                    grp_valid,
	output mrd_data_pkg::rd_group_t                 grp,
	output logic                                    rd_end
);
	import mrd_ctrl_pkg::*;
	import mrd_data_pkg::*;

	localparam int unsigned ROWS = 1 << `MRD_ROW_W;
	localparam int unsigned NUM_WORDS = `MRD_NUM_BANKS * ROWS;

	sample_t mem [`MRD_NUM_BANKS][ROWS];
	sample_t rd_q [`MRD_NUM_BANKS];

	bank_t  wr_bank;
	row_t   wr_row;

	logic                       d_valid;
	logic                       d_last;
	radix_t                     d_radix;
	stage_t                     d_stage;
	bank_t [`MRD_MAX_RDX-1:0]   d_lane_bank;

	// ------------------------------
	// banks
	// ------------------------------
	always_comb
		bank_split(wr_addr, wr_bank, wr_row);

	always_ff @(posedge clk)
	begin
		if (wr_valid && wr_addr < addr_t'(NUM_WORDS))
			mem[wr_bank][wr_row] <= wr_data;
		for (int k = 0; k < `MRD_NUM_BANKS; k++)
		begin
			if (rd_en[k])
				rd_q[k] <= mem[k][rd_row[k]];
		end
	end

	// control rides along with the ram read
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			d_valid <= 1'b0;
			d_last <= 1'b0;
		end
		else
		begin
			d_valid <= req_valid;
			d_last <= req_last;
		end
	end

	always_ff @(posedge clk)
	begin
		d_radix <= req_radix;
		d_stage <= req_stage;
		d_lane_bank <= lane_bank;
	end

	// ------------------------------
	// gather into lane order
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			grp_valid <= 1'b0;
			rd_end <= 1'b0;
		end
		else
		begin
			grp_valid <= d_valid;
			rd_end <= d_valid && d_last;
		end
	end

	always_ff @(posedge clk)
	begin
		grp.radix <= d_radix;
		grp.stage <= d_stage;
		for (int m = 0; m < `MRD_MAX_RDX; m++)
		begin
			if (d_lane_bank[m] < bank_t'(`MRD_NUM_BANKS))
				grp.smp[m] <= rd_q[d_lane_bank[m]];
			else
				grp.smp[m] <= '0;
		end
	end

endmodule

//--- design/mrd_read_top.sv
`timescale 1ns/1ps
`include "mrd_cfg.svh"

module mrd_read_top
(
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        start,
	input  mrd_ctrl_pkg::xform_cfg_t    cfg,
	input  logic                        wr_valid,
	input  mrd_data_pkg::addr_t         wr_addr,
	input  mrd_data_pkg::sample_t       wr_data,
	output logic                        grp_valid,
	output mrd_data_pkg::rd_group_t     grp,
	output logic                        busy,
	output logic                        rd_end
);
	import mrd_ctrl_pkg::*;
	import mrd_data_pkg::*;

	bfly_cmd_t                  cmd;

	// address stage to bank map
	logic                       op_valid;
	logic                       op_last;
	radix_t                     op_radix;
	stage_t                     op_stage;
	addr_t [`MRD_MAX_RDX-1:0]   op_addr;

	// bank map to memory
	logic [`MRD_NUM_BANKS-1:0]  rd_en;
	row_t [`MRD_NUM_BANKS-1:0]  rd_row;
	bank_t [`MRD_MAX_RDX-1:0]   lane_bank;
	logic                       req_valid;
	logic                       req_last;
	radix_t                     req_radix;
	stage_t                     req_stage;

	mrd_stage_seq u_seq
	(
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (start),
		.cfg    (cfg),
		.cmd    (cmd),
		.busy   (busy)
	);

	mrd_bfly_addr u_addr
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.cmd        (cmd),
		.op_valid   (op_valid),
		.op_last    (op_last),
		.op_radix   (op_radix),
		.op_stage   (op_stage),
		.op_addr    (op_addr)
	);

	mrd_bank_map u_map
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.op_valid   (op_valid),
		.op_last    (op_last),
		.op_radix   (op_radix),
		.op_stage   (op_stage),
		.op_addr    (op_addr),
		.rd_en      (rd_en),
		.rd_row     (rd_row),
		.lane_bank  (lane_bank),
		.req_valid  (req_valid),
		.req_last   (req_last),
		.req_radix  (req_radix),
		.req_stage  (req_stage)
	);

	mrd_bank_mem u_mem
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_valid   (wr_valid),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.rd_en      (rd_en),
		.rd_row     (rd_row),
		.lane_bank  (lane_bank),
		.req_valid  (req_valid),
		.req_last   (req_last),
		.req_radix  (req_radix),
		.req_stage  (req_stage),
		.grp_valid  (grp_valid),
		.grp        (grp),
		.rd_end     (rd_end)
	);

endmodule

//--- dv/mrd_read_model.svh
`ifndef MRD_READ_MODEL_SVH
`define MRD_READ_MODEL_SVH

// ------------------------------
// reference memory and expected groups
// ------------------------------
sample_t   ref_mem [`MRD_NUM_BANKS << `MRD_ROW_W];
rd_group_t exp_q [$];

// product of the radices of the later stages
function automatic int stage_stride(input xform_cfg_t c, input int s);
	int p;
	p = 1;
	for (int j = s + 1; j < int'(c.n_stg); j++)
		p = p * int'(c.rdx[j]);
	return p;
endfunction

// product of the radices of the earlier stages
function automatic int stage_blocks(input xform_cfg_t c, input int s);
	int p;
	p = 1;
	for (int j = 0; j < s; j++)
		p = p * int'(c.rdx[j]);
	return p;
endfunction

// points over radix, summed over all stages
function automatic int expected_group_count(input xform_cfg_t c);
	int points;
	int total;
	points = 1;
	total = 0;
	for (int s = 0; s < int'(c.n_stg); s++)
		points = points * int'(c.rdx[s]);
	for (int s = 0; s < int'(c.n_stg); s++)
		total = total + points / int'(c.rdx[s]);
	return total;
endfunction

// offset fastest, then block, then stage
task automatic expand_config(input xform_cfg_t c);
	int r;
	int stride;
	int blocks;
	rd_group_t g;
	exp_q.delete();
	for (int s = 0; s < int'(c.n_stg); s++)
	begin
		r = int'(c.rdx[s]);
		stride = stage_stride(c, s);
		blocks = stage_blocks(c, s);
		for (int b = 0; b < blocks; b++)
		begin
			for (int o = 0; o < stride; o++)
			begin
				g = '0;
				g.radix = c.rdx[s];
				g.stage = stage_t'(s);
				for (int m = 0; m < r; m++)
					g.smp[m] = ref_mem[b * r * stride + m * stride + o];
				exp_q.push_back(g);
			end
		end
	end
endtask

// ------------------------------
// compare tasks
// ------------------------------
task automatic check_group(input string name, input rd_group_t exp, input rd_group_t act);
	if (act !== exp)
	begin
		$display("Mismatch %s expected %h actual %h", name, exp, act);
		stop_on_error();
	end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	if (act !== exp)
	begin
		$display("Mismatch %s expected %b actual %b", name, exp, act);
		stop_on_error();
	end
endtask

task automatic check_count(input string name, input int exp, input int act);
	if (act != exp)
	begin
		$display("Mismatch %s expected %0d actual %0d", name, exp, act);
		stop_on_error();
	end
endtask

`endif

//--- dv/mrd_read_tb.sv
`timescale 1ns/1ps
`include "mrd_cfg.svh"

module mrd_read_tb;
	import mrd_data_pkg::*;
	import mrd_ctrl_pkg::*;

	localparam int NUM_WORDS = `MRD_NUM_BANKS << `MRD_ROW_W;
	// start to first group
	localparam int LATENCY = 5;
	localparam int MARGIN = 8;

	logic       clk;
	logic       rst_n;
	logic       start;
	xform_cfg_t cfg;
	logic       wr_valid;
	addr_t      wr_addr;
	sample_t    wr_data;
	logic       grp_valid;
	rd_group_t  grp;
	logic       busy;
	logic       rd_end;
	integer     seed;

	task automatic stop_on_error();
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	`include "mrd_read_model.svh"

	mrd_read_top uut
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.cfg        (cfg),
		.wr_valid   (wr_valid),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.grp_valid  (grp_valid),
		.grp        (grp),
		.busy       (busy),
		.rd_end     (rd_end)
	);

	initial
		clk = 1'b0;
	always #2 clk = ~clk;

	function automatic xform_cfg_t random_config();
		xform_cfg_t c;
		c.n_stg = stage_t'(1 + {$random(seed)} % 3);
		// radices in unused slots too
		for (int j = 0; j < `MRD_MAX_STG; j++)
			c.rdx[j] = radix_t'(2 + {$random(seed)} % 4);
		return c;
	endfunction

	task automatic expect_idle(input string name, input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			check_flag({name, " grp_valid"}, 1'b0, grp_valid);
			check_flag({name, " rd_end"}, 1'b0, rd_end);
			check_flag({name, " busy"}, 1'b0, busy);
			@(negedge clk);
		end
	endtask

	// ------------------------------
	// one transform run
	// ------------------------------
	task automatic run_config(input xform_cfg_t c, input string name, input bit poke);
		int  cycle;
		int  got;
		int  limit;
		bit  done;
		expand_config(c);
		limit = exp_q.size() + int'(c.n_stg) + LATENCY + MARGIN;
		got = 0;
		done = 1'b0;
		cfg = c;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		cycle = 1;
		while (!done)
		begin
			check_flag({name, " busy"}, 1'b1, busy);
			if (grp_valid)
			begin
				if (got == 0)
					check_count({name, " first group latency"}, LATENCY, cycle);
				if (exp_q.size() == 0)
				begin
					$display("%s produced a group after the last expected one", name);
					stop_on_error();
				end
				check_group(name, exp_q.pop_front(), grp);
				got++;
			end
			if (rd_end)
			begin
				check_count({name, " group count"}, expected_group_count(c), got);
				check_flag({name, " rd_end on last group"}, 1'b1, grp_valid);
				done = 1'b1;
			end
			// second start lands while busy
			start = poke && cycle == 2;
			if (poke && cycle == 2)
				cfg = random_config();
			@(negedge clk);
			cycle++;
			if (!done && cycle > limit)
			begin
				$display("timeout in %s: no rd_end seen within %0d cycles", name, limit);
				stop_on_error();
			end
		end
		expect_idle({name, " after end"}, 3);
	endtask

	initial
	begin
		xform_cfg_t  fixed;
		logic [63:0] word;
		seed = 28250;
		rst_n = 1'b0;
		start = 1'b0;
		cfg = '0;
		wr_valid = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		expect_idle("after reset", 8);

		// ------------------------------
		// load every bank row
		// ------------------------------
		for (int a = 0; a < NUM_WORDS; a++)
		begin
			word = {$random(seed), $random(seed)};
			ref_mem[a] = word[35:0];
			wr_valid = 1'b1;
			wr_addr = addr_t'(a);
			wr_data = word[35:0];
			@(negedge clk);
			check_flag("load busy", 1'b0, busy);
		end
		wr_valid = 1'b0;

		fixed.n_stg = 2'd3;
		fixed.rdx[0] = 3'd4;
		fixed.rdx[1] = 3'd3;
		fixed.rdx[2] = 3'd5;
		run_config(fixed, "fixed 4x3x5", 1'b0);

		for (int i = 0; i < 20; i++)
			run_config(random_config(), $sformatf("random %0d", i), 1'b0);

		run_config(random_config(), "start while busy", 1'b1);

		$display("Simulation passed");
		$finish;
	end

endmodule

//--- mrd_read_top.f
+incdir+design
+incdir+dv
design/mrd_data_pkg.sv
design/mrd_ctrl_pkg.sv
design/mrd_stage_seq.sv
design/mrd_bfly_addr.sv
design/mrd_bank_map.sv
design/mrd_bank_mem.sv
design/mrd_read_top.sv
dv/mrd_read_tb.sv

//--- Bender.yml
package:
  name: mrd_read

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/mrd_data_pkg.sv
      - design/mrd_ctrl_pkg.sv
      - design/mrd_stage_seq.sv
      - design/mrd_bfly_addr.sv
      - design/mrd_bank_map.sv
      - design/mrd_bank_mem.sv
      - design/mrd_read_top.sv
  - target: test
    include_dirs:
      - design
      - dv
    files:
      - dv/mrd_read_tb.sv
